// ==== common/div_types_pkg.sv ====
package div_types_pkg;

  // Operand width shared by the whole divider
  localparam int unsigned DIV_W = 16;

  // One word of dividend, divisor, quotient or remainder
  typedef logic [DIV_W-1:0] div_data_t;

  // Running residue, one bit wider so residue plus remainder cannot overflow
  typedef logic [DIV_W:0] div_res_acc_t;

  // Operands captured on an accepted start
  typedef struct packed {
    div_data_t dividend;
    div_data_t divisor;
  } div_operands_t;

  // Quotient and remainder of one division
  typedef struct packed {
    div_data_t quotient;
    div_data_t remainder;
  } div_result_t;

endpackage

// ==== common/div_ctrl_pkg.sv ====
package div_ctrl_pkg;

  // Sequencing states of the divider control
  typedef enum logic [1:0] {
    ST_IDLE, // Waiting for the first start
    ST_RUN,  // Shift-subtract iterations
    ST_ACC,  // Remainder folded into the residue
    ST_DONE  // Result valid until the next start
  } div_state_t;

  // Iteration count, wide enough to hold DIV_W itself
  typedef logic [$clog2(div_types_pkg::DIV_W+1)-1:0] div_cnt_t;

endpackage

// ==== subshift/div_iter_counter.sv ====
`timescale 1ns/10ps

module div_iter_counter
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic load_i,
  input  logic step_i,
  output logic last_o
);

  localparam div_cnt_t LAST_CNT = div_cnt_t'(DIV_W - 1);
  localparam div_cnt_t FULL_CNT = div_cnt_t'(DIV_W);

  div_cnt_t cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= '0; // New division restarts the count
    end else if (step_i) begin
      cnt_q <= cnt_q + div_cnt_t'(1);
    end
  end

  assign last_o = step_i && (cnt_q == LAST_CNT); // Final iteration in progress

  // The controller must stop stepping once all quotient bits are in
  a_no_step_past_end: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    step_i |-> (cnt_q != FULL_CNT)
  ) else $error("div_iter_counter: step after %0d iterations", DIV_W);

  // Stepping stops right after the final iteration
  a_last_after_full_run: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    last_o |=> !step_i
  ) else $error("div_iter_counter: stepping continued after last");

endmodule

// ==== subshift/div_subshift_core.sv ====
`timescale 1ns/10ps

module div_subshift_core
  import div_types_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          load_i,
  input  logic          step_i,
  input  div_operands_t operands_i,
  output div_data_t     divisor_o,
  output div_result_t   raw_result_o
);

  // Latched divisor and the register that turns dividend bits into quotient bits
  div_data_t divisor_q;
  div_data_t shift_q;
  div_data_t rem_q;

  // Trial remainder after shifting in the next dividend bit
  logic [DIV_W:0] rem_shift;
  logic [DIV_W:0] rem_diff;
  logic           q_bit;

  assign rem_shift = {rem_q, shift_q[DIV_W-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_q};
  assign q_bit     = (rem_shift >= {1'b0, divisor_q}); // Restoring decision

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      divisor_q <= operands_i.divisor;
      shift_q   <= operands_i.dividend;
      rem_q     <= '0;
    end else if (step_i) begin
      // Dividend bits leave at the top while quotient bits enter at the bottom
      shift_q <= {shift_q[DIV_W-2:0], q_bit};
      if (q_bit) begin
        rem_q <= rem_diff[DIV_W-1:0]; // Fits since rem_q stays below the divisor
      end else begin
        rem_q <= rem_shift[DIV_W-1:0];
      end
    end
  end

  assign divisor_o              = divisor_q;
  assign raw_result_o.quotient  = shift_q;
  assign raw_result_o.remainder = rem_q;

  // Division by zero is never issued by the user
  a_divisor_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    load_i |=> (divisor_q != '0)
  ) else $error("div_subshift_core: division by zero loaded");

  // The partial remainder stays below the divisor through every iteration
  a_rem_below_divisor: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    step_i |=> (rem_q < divisor_q)
  ) else $error("div_subshift_core: partial remainder out of range");

endmodule

// ==== hdl/frac_div_ctrl.sv ====
`timescale 1ns/10ps

module frac_div_ctrl
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic last_i,
  output logic load_o,
  output logic step_o,
  output logic acc_en_o,
  output logic done_o
);

  div_state_t state_q;
  div_state_t state_d;
  logic       done_q;
  logic       accept;

  // Start only counts while no division is in flight
  assign accept = start_i && ((state_q == ST_IDLE) || (state_q == ST_DONE));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_DONE: begin
        if (start_i) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        if (last_i) begin
          state_d = ST_ACC;
        end
      end
      ST_ACC:  state_d = ST_DONE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        done_q <= 1'b0; // A new start withdraws the old result
      end else if (state_q == ST_ACC) begin
        done_q <= 1'b1;
      end
    end
  end

  assign load_o   = accept;
  assign step_o   = (state_q == ST_RUN);
  assign acc_en_o = (state_q == ST_ACC);
  assign done_o   = done_q;

  // Accumulation happens only right after the final iteration
  a_acc_after_run: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    acc_en_o |-> !step_o && $past(step_o)
  ) else $error("frac_div_ctrl: accumulate overlaps or skips iteration");

  // Fixed latency from the accepted start to the result, seen one edge after the accumulation
  a_fixed_latency: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    load_o |-> ##(DIV_W+2) done_o
  ) else $error("frac_div_ctrl: done not reached after %0d cycles", DIV_W+1);

endmodule

// ==== hdl/residue_accum.sv ====
`timescale 1ns/10ps

module residue_accum
  import div_types_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        acc_en_i,
  input  div_data_t   divisor_i,
  input  div_result_t raw_result_i,
  output div_result_t result_o
);

  div_res_acc_t residue_q;
  div_res_acc_t acc_sum;
  div_res_acc_t acc_wrap;
  div_res_acc_t divisor_ext;
  logic         incr;
  div_result_t  result_q;

  assign divisor_ext = div_res_acc_t'(divisor_i);
  assign acc_sum     = residue_q + div_res_acc_t'(raw_result_i.remainder);
  assign acc_wrap    = acc_sum - divisor_ext;
  assign incr        = (acc_sum >= divisor_ext); // A whole divisor has built up

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      residue_q <= '0;
      result_q  <= '0;
    end else if (acc_en_i) begin
      if (incr) begin
        residue_q <= acc_wrap;
      end else begin
        residue_q <= acc_sum;
      end
      result_q.quotient  <= raw_result_i.quotient + div_data_t'(incr);
      result_q.remainder <= raw_result_i.remainder;
    end
  end

  assign result_o = result_q;

  // The residue keeps within one word, so residue plus remainder always fits the sum
  a_residue_bounded: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    acc_en_i |=> !residue_q[DIV_W]
  ) else $error("residue_accum: residue grew past one word");

endmodule

// ==== hdl/frac_div_top.sv ====
`timescale 1ns/10ps

module frac_div_top
  import div_types_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  div_operands_t operands_i,
  output logic          done_o,
  output div_result_t   result_o
);

  logic        load;
  logic        step;
  logic        last;
  logic        acc_en;
  div_data_t   divisor;    // Divisor the core actually used
  div_result_t raw_result; // Quotient and remainder before residue correction

  frac_div_ctrl u_frac_div_ctrl (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (start_i),
    .last_i   (last),
    .load_o   (load),
    .step_o   (step),
    .acc_en_o (acc_en),
    .done_o   (done_o)
  );

  div_iter_counter u_div_iter_counter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .load_i  (load),
    .step_i  (step),
    .last_o  (last)
  );

  div_subshift_core u_div_subshift_core (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .load_i       (load),
    .step_i       (step),
    .operands_i   (operands_i),
    .divisor_o    (divisor),
    .raw_result_o (raw_result)
  );

  // Folds each remainder into the running residue
  residue_accum u_residue_accum (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .acc_en_i     (acc_en),
    .divisor_i    (divisor),
    .raw_result_i (raw_result),
    .result_o     (result_o)
  );

endmodule

// ==== tests/tb_frac_div.sv ====
`timescale 1ns/10ps

module tb_frac_div
  import div_types_pkg::*;
();

  localparam int NUM_DIVS       = 232; // Every start issued, ignored ones included
  localparam int TIMEOUT_CYCLES = 30 * NUM_DIVS + 100;
  localparam int DONE_LIMIT     = 2 * (DIV_W + 1) + 10;

  logic          clk;
  logic          rst_n;
  logic          start;
  div_operands_t operands;
  logic          done;
  div_result_t   result;

  int           seed = 32'hc40cc2b8;
  int           cycle_cnt = 0;
  div_res_acc_t model_residue = '0;
  div_result_t  expected_q[$];
  div_result_t  last_result;
  div_result_t  mon_expected;
  int           mon_latency;
  int           start_cycle = 0;
  int           checked_cnt = 0;
  int           drv_errors = 0;
  int           mon_errors = 0;
  int           tests_run = 0;
  int           tests_failed = 0;
  logic         busy = 1'b0;
  logic         done_prev = 1'b0;

  frac_div_top u_frac_div_top (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .start_i    (start),
    .operands_i (operands),
    .done_o     (done),
    .result_o   (result)
  );

  always #20 clk = ~clk;

  // Exact division followed by the residue threshold rule
  function automatic div_result_t ref_divide(input div_data_t dividend, input div_data_t divisor);
    div_result_t  r;
    div_res_acc_t sum;
    r.quotient  = dividend / divisor;
    r.remainder = dividend % divisor;
    sum = model_residue + div_res_acc_t'(r.remainder);
    if (sum >= {1'b0, divisor}) begin
      model_residue = sum - {1'b0, divisor};
      r.quotient    = r.quotient + 16'd1;
    end else begin
      model_residue = sum;
    end
    return r;
  endfunction

  function automatic int total_errors();
    return drv_errors + mon_errors;
  endfunction

  task automatic issue_start(input div_data_t dividend, input div_data_t divisor);
    @(posedge clk);
    start             <= 1'b1;
    operands.dividend <= dividend;
    operands.divisor  <= divisor;
    @(posedge clk);
    start <= 1'b0; // Returns right after the sampling edge
  endtask

  task automatic wait_result(input int target);
    int cycles;
    cycles = 0;
    while ((checked_cnt < target) && (cycles < DONE_LIMIT)) begin
      @(posedge clk);
      cycles++;
    end
    if (checked_cnt < target) begin
      $display("Error at %0t: done did not rise within %0d cycles of the start", $time,
               DONE_LIMIT);
      drv_errors++;
    end
  endtask

  task automatic run_division(input div_data_t dividend, input div_data_t divisor);
    int target;
    expected_q.push_back(ref_divide(dividend, divisor));
    target = expected_q.size();
    issue_start(dividend, divisor);
    wait_result(target);
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errs);
    end
  endtask

  task automatic test_exact();
    div_data_t dividends [6];
    div_data_t divisors [6];
    int        errs_before;
    dividends   = '{16'd100, 16'd65535, 16'd48, 16'd1000, 16'd4096, 16'd21};
    divisors    = '{16'd10, 16'd5, 16'd16, 16'd8, 16'd64, 16'd7};
    errs_before = total_errors();
    for (int i = 0; i < 6; i++) begin
      run_division(dividends[i], divisors[i]);
      if ((last_result.remainder !== '0) ||
          (last_result.quotient !== dividends[i] / divisors[i])) begin
        $display("Mismatch at %0t: exact %0d / %0d gave q %0d r %0d", $time, dividends[i],
                 divisors[i], last_result.quotient, last_result.remainder);
        drv_errors++;
      end
    end
    report_test("exact division", errs_before);
  endtask

  task automatic test_averaging();
    int errs_before;
    int q_sum;
    errs_before = total_errors();
    q_sum       = 0;
    for (int i = 0; i < 12; i++) begin
      run_division(16'd10, 16'd3);
      q_sum += int'(last_result.quotient);
    end
    if (q_sum != 40) begin // Twelve times 10 by 3 must total 120 by 3
      $display("Mismatch at %0t: quotient sum %0d, expected 40", $time, q_sum);
      drv_errors++;
    end
    report_test("fraction averaging", errs_before);
  endtask

  task automatic test_random();
    int          errs_before;
    logic [31:0] rnd;
    div_data_t   dividend;
    div_data_t   divisor;
    errs_before = total_errors();
    for (int i = 0; i < 200; i++) begin
      rnd      = $random(seed);
      dividend = rnd[15:0];
      divisor  = (i % 2 == 0) ? rnd[31:16] : {8'h00, rnd[23:16]}; // Small divisors too
      if (divisor == '0) begin
        divisor = 16'd1;
      end
      run_division(dividend, divisor);
    end
    report_test("random operands", errs_before);
  endtask

  task automatic test_busy_start();
    int errs_before;
    int target;
    errs_before = total_errors();
    expected_q.push_back(ref_divide(16'd50000, 16'd7));
    target = expected_q.size();
    issue_start(16'd50000, 16'd7);
    repeat (4) @(posedge clk);
    issue_start(16'd1234, 16'd5); // Lands in the middle of the iterations
    wait_result(target);
    expected_q.push_back(ref_divide(16'd999, 16'd4));
    target = expected_q.size();
    issue_start(16'd999, 16'd4);
    @(negedge clk);
    if (done !== 1'b0) begin
      $display("Error at %0t: done stayed high after a start in the done state", $time);
      drv_errors++;
    end
    wait_result(target);
    report_test("start while busy", errs_before);
  endtask

  task automatic test_edge_operands();
    int errs_before;
    errs_before = total_errors();
    run_division(16'd12345, 16'd1);
    run_division(16'hFFFF, 16'd1);
    run_division(16'd40000, 16'hFFFF);
    run_division(16'hFFFF, 16'hFFFF);
    run_division(16'd0, 16'd77);
    run_division(16'hFFFF, 16'd1000);
    report_test("edge operands", errs_before);
  endtask

  task automatic test_reset();
    int errs_before;
    errs_before = total_errors();
    run_division(16'd7, 16'd4);
    run_division(16'd7, 16'd4); // Leaves done high and a residue behind
    repeat (5) @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    model_residue = '0;
    @(negedge clk);
    if (done !== 1'b0) begin
      $display("Error at %0t: done is high right after reset", $time);
      drv_errors++;
    end
    if (result !== '0) begin
      $display("Mismatch at %0t: result %h after reset, expected zero", $time, result);
      drv_errors++;
    end
    for (int i = 0; i < 3; i++) begin
      run_division(16'd7, 16'd4);
    end
    report_test("reset clears state", errs_before);
  endtask

  // Result comparison and latency measurement on each rising done
  always @(negedge clk) begin
    if (!rst_n) begin
      busy      = 1'b0;
      done_prev = 1'b0;
    end else begin
      if (start && !busy) begin
        busy        = 1'b1;
        start_cycle = cycle_cnt;
      end
      if (done && !done_prev) begin
        busy        = 1'b0;
        mon_latency = cycle_cnt - start_cycle - 1; // Counted from the sampling edge
        if (checked_cnt >= expected_q.size()) begin
          $display("Error at %0t: done rose with no division outstanding", $time);
          mon_errors++;
        end else begin
          mon_expected = expected_q[checked_cnt];
          if (result !== mon_expected) begin
            $display("Mismatch at %0t: got q %0d r %0d, expected q %0d r %0d", $time,
                     result.quotient, result.remainder, mon_expected.quotient,
                     mon_expected.remainder);
            mon_errors++;
          end
          if (mon_latency != int'(DIV_W) + 1) begin
            $display("Mismatch at %0t: latency %0d cycles, expected %0d", $time,
                     mon_latency, DIV_W + 1);
            mon_errors++;
          end
          last_result = result;
          checked_cnt++;
        end
      end
      done_prev = done;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Error: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    start    = 1'b0;
    operands = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_exact();
    test_averaging();
    test_random();
    test_busy_start();
    test_edge_operands();
    test_reset();
    $display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors", tests_run,
             tests_failed, checked_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
common/div_types_pkg.sv
common/div_ctrl_pkg.sv
subshift/div_iter_counter.sv
subshift/div_subshift_core.sv
hdl/frac_div_ctrl.sv
hdl/residue_accum.sv
hdl/frac_div_top.sv
tests/tb_frac_div.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f tb.f --top-module tb_frac_div

# The simulation output decides the result
sim_out=$(./obj_dir/Vtb_frac_div || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "^STATUS: PASS$"; then
  exit 0
else
  exit 1
fi
